/* Makefile */
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_load_store_unit
FILELIST  ?= load_store_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "tests failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module load_store_unit (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire lsu_pkg::ls_request_t   ls_inputs,
    input  wire logic                   new_request,
    input  wire logic                   wb_accepted,
    output logic                        ready,
    output logic                        wb_valid,
    output logic [31:0]                 wb_rd,
    output logic                        exception_valid,
    output lsu_pkg::ls_exception_t      ls_exception
);

    localparam int CW = $clog2(`LSU_WB_DEPTH + 1);

    typedef logic [CW:0] budget_t;
    localparam budget_t WB_LIMIT = budget_t'(`LSU_WB_DEPTH);

    lsu_pkg::ls_request_t  head;
    lsu_pkg::mem_access_t  access;
    lsu_pkg::load_attr_t   attr_in;
    lsu_pkg::load_attr_t   attr_head;
    logic                  head_valid;
    logic                  req_full;
    logic                  issue;
    logic                  attr_push;
    logic                  attr_valid;
    logic                  wb_budget_full;
    logic [31:0]           ram_data;
    logic                  data_valid;
    logic [31:0]           load_data;
    logic [CW-1:0]         wb_count;
    logic [CW-1:0]         loads_in_flight;
    budget_t               budget_used;

    // request buffer
    lsu_fifo #(.payload_t(lsu_pkg::ls_request_t), .DEPTH(`LSU_REQ_DEPTH)) u_req_fifo (
        .clk(clk),
        .rst(rst),
        .push(new_request),
        .pop(issue || exception_valid),
        .data_in(ls_inputs),
        .data_out(head),
        .valid(head_valid),
        .full(req_full),
        .count()
    );

    assign ready = !req_full;

    lsu_address_stage u_address_stage (
        .clk(clk),
        .rst(rst),
        .head(head),
        .head_valid(head_valid),
        .wb_budget_full(wb_budget_full),
        .issue(issue),
        .attr_push(attr_push),
        .access(access),
        .attr(attr_in),
        .exception_valid(exception_valid),
        .ls_exception(ls_exception)
    );

    lsu_scratch_ram u_scratch_ram (
        .clk(clk),
        .rst(rst),
        .new_request(issue),
        .access(access),
        .data_out(ram_data),
        .data_valid(data_valid)
    );

    // one entry per load between issue and RAM data
    lsu_fifo #(.payload_t(lsu_pkg::load_attr_t), .DEPTH(`LSU_WB_DEPTH)) u_attr_fifo (
        .clk(clk),
        .rst(rst),
        .push(attr_push),
        .pop(data_valid),
        .data_in(attr_in),
        .data_out(attr_head),
        .valid(attr_valid),
        .full(),
        .count()
    );

    lsu_load_align u_load_align (
        .raw_data(ram_data),
        .attr(attr_head),
        .load_data(load_data)
    );

    // results wait here for the writeback side
    lsu_fifo #(.payload_t(logic [31:0]), .DEPTH(`LSU_WB_DEPTH)) u_wb_fifo (
        .clk(clk),
        .rst(rst),
        .push(data_valid),
        .pop(wb_accepted),
        .data_in(load_data),
        .data_out(wb_rd),
        .valid(wb_valid),
        .full(),
        .count(wb_count)
    );

    // loads issued but not yet back from the RAM
    always_ff @(posedge clk) begin
        if (rst) begin
            loads_in_flight <= '0;
        end else if (attr_push && !data_valid) begin
            loads_in_flight <= loads_in_flight + 1'b1;
        end else if (data_valid && !attr_push) begin
            loads_in_flight <= loads_in_flight - 1'b1;
        end
    end

    // every in-flight load needs a free writeback slot on return
    assign budget_used = {1'b0, loads_in_flight} + {1'b0, wb_count};
    assign wb_budget_full = (budget_used >= WB_LIMIT);

    a_accept_valid: assert property (@(posedge clk) disable iff (rst)
        wb_accepted |-> wb_valid)
        else $error("wb_accepted without wb_valid");

    // RAM data always has a matching attribute entry
    a_attr_present: assert property (@(posedge clk) disable iff (rst)
        data_valid |-> attr_valid)
        else $error("load data without attributes");

endmodule

`default_nettype wire

/* hdl/lsu_address_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_address_stage (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire lsu_pkg::ls_request_t   head,
    input  wire logic                   head_valid,
    input  wire logic                   wb_budget_full,
    output logic                        issue,
    output logic                        attr_push,
    output lsu_pkg::mem_access_t        access,
    output lsu_pkg::load_attr_t         attr,
    output logic                        exception_valid,
    output lsu_pkg::ls_exception_t      ls_exception
);

    localparam logic [31:0] SCRATCH_BASE = `LSU_SCRATCH_BASE;

    logic [31:0] eff_addr;
    logic        misaligned;
    logic        in_region;
    logic        fault;
    logic [3:0]  be;
    logic [31:0] store_data;

    // base plus sign-extended 12-bit offset
    assign eff_addr = head.base + {{20{head.offset[11]}}, head.offset};

    // halfwords need bit 0 clear, words need both low bits clear
    always_comb begin
        case (head.fn3)
            lsu_pkg::LS_H, lsu_pkg::LS_HU: misaligned = eff_addr[0];
            lsu_pkg::LS_W: misaligned = |eff_addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // only the scratch region exists, no other sub-unit
    assign in_region = (eff_addr[31 -: `LSU_SCRATCH_BITS]
        == SCRATCH_BASE[31 -: `LSU_SCRATCH_BITS]);
    assign fault = misaligned || !in_region;

    // byte enables, stores only
    always_comb begin
        be = 4'b0000;
        if (head.store) begin
            case (head.fn3[1:0])
                2'b00: be = 4'b0001 << eff_addr[1:0];
                2'b01: be = eff_addr[1] ? 4'b1100 : 4'b0011;
                default: be = 4'b1111;
            endcase
        end
    end

    // replicate narrow store data into every lane
    always_comb begin
        case (head.fn3[1:0])
            2'b00: store_data = {4{head.rs2[7:0]}};
            2'b01: store_data = {2{head.rs2[15:0]}};
            default: store_data = head.rs2;
        endcase
    end

    // loads wait for writeback room, stores go straight through
    assign issue = head_valid && !fault && !(head.load && wb_budget_full);
    assign attr_push = issue && head.load;

    assign access.word_addr = eff_addr[31:2];
    assign access.be = be;
    assign access.data_in = store_data;
    assign access.load = head.load;
    assign access.store = head.store;

    assign attr.fn3 = head.fn3;
    assign attr.byte_addr = eff_addr[1:0];

    // faulting head is dropped in the same cycle
    assign exception_valid = head_valid && fault;
    assign ls_exception.addr = eff_addr;
    assign ls_exception.misaligned = misaligned;
    assign ls_exception.access_fault = !in_region;

    // a stalled head must stay put until it issues
    a_head_stable: assert property (@(posedge clk) disable iff (rst)
        head_valid && !issue && !exception_valid |=> head_valid && $stable(head))
        else $error("request head changed while stalled");

endmodule

`default_nettype wire

/* hdl/lsu_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 4
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         push,
    input  wire logic                         pop,
    input  wire payload_t                     data_in,
    output payload_t                          data_out,
    output logic                              valid,
    output logic                              full,
    output logic [$clog2(DEPTH+1)-1:0]        count
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t storage [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        logic [PW-1:0] nxt;
        if (ptr == PW'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // occupancy holds when both happen
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            storage[wr_ptr] <= data_in;
        end
    end

    // head straight from the storage registers
    assign data_out = storage[rd_ptr];
    assign valid = (count != '0);
    assign full = (count == ($clog2(DEPTH+1))'(DEPTH));

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("fifo push while full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> valid)
        else $error("fifo pop while empty");

endmodule

`default_nettype wire

/* hdl/lsu_load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  wire logic [31:0]            raw_data,
    input  wire lsu_pkg::load_attr_t    attr,
    output logic [31:0]                 load_data
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // byte lane by the two low address bits
    always_comb begin
        case (attr.byte_addr)
            2'd0: byte_lane = raw_data[7:0];
            2'd1: byte_lane = raw_data[15:8];
            2'd2: byte_lane = raw_data[23:16];
            default: byte_lane = raw_data[31:24];
        endcase
    end

    // halfwords are aligned, so bit 1 is enough
    assign half_lane = attr.byte_addr[1] ? raw_data[31:16] : raw_data[15:0];

    // extend by fn3
    always_comb begin
        case (attr.fn3)
            lsu_pkg::LS_B: load_data = {{24{byte_lane[7]}}, byte_lane};
            lsu_pkg::LS_H: load_data = {{16{half_lane[15]}}, half_lane};
            lsu_pkg::LS_BU: load_data = {24'd0, byte_lane};
            lsu_pkg::LS_HU: load_data = {16'd0, half_lane};
            default: load_data = raw_data;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// request buffer entries ahead of the address stage
`define LSU_REQ_DEPTH 4

// writeback buffer entries, also the cap on loads in flight
`define LSU_WB_DEPTH 2

// scratch region, matched on the upper address bits
`define LSU_SCRATCH_BASE 32'h8000_0000
`define LSU_SCRATCH_BITS 20

// scratch memory size in 32-bit words (4 KiB region)
`define LSU_RAM_WORDS 1024

`endif

/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // access size and signedness, standard RISC-V fn3 encoding
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_fn3_t;

    // one request from issue
    typedef struct packed {
        logic [31:0]        base;
        logic signed [11:0] offset;
        logic [31:0]        rs2;
        ls_fn3_t            fn3;
        logic               load;
        logic               store;
    } ls_request_t;

    // one access to the scratch memory
    typedef struct packed {
        logic [29:0] word_addr;
        logic [3:0]  be;
        logic [31:0] data_in;
        logic        load;
        logic        store;
    } mem_access_t;

    // kept per load until its data returns
    typedef struct packed {
        ls_fn3_t    fn3;
        logic [1:0] byte_addr;
    } load_attr_t;

    // fault report, valid with exception_valid
    typedef struct packed {
        logic [31:0] addr;
        logic        misaligned;
        logic        access_fault;
    } ls_exception_t;

endpackage

`default_nettype wire

/* hdl/lsu_scratch_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_scratch_ram (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   new_request,
    input  wire lsu_pkg::mem_access_t   access,
    output logic [31:0]                 data_out,
    output logic                        data_valid
);

    localparam int AW = $clog2(`LSU_RAM_WORDS);

    logic [31:0] mem [`LSU_RAM_WORDS];
    logic [AW-1:0] index;

    // region check already done, low word bits pick the entry
    assign index = access.word_addr[AW-1:0];

    // byte-enabled write, registered read
    always_ff @(posedge clk) begin
        if (new_request && access.store) begin
            for (int i = 0; i < 4; i++) begin
                if (access.be[i]) begin
                    mem[index][i*8 +: 8] <= access.data_in[i*8 +: 8];
                end
            end
        end
        if (new_request && access.load) begin
            data_out <= mem[index];
        end
    end

    // one-cycle load latency
    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= new_request && access.load;
        end
    end

endmodule

`default_nettype wire

/* load_store_unit.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_fifo.sv
hdl/lsu_address_stage.sv
hdl/lsu_scratch_ram.sv
hdl/lsu_load_align.sv
hdl/load_store_unit.sv
testbench/tb_load_store_unit.sv

/* testbench/tb_load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module tb_load_store_unit;

    localparam int WAIT_LIMIT = 200;
    localparam int WINDOW_WORDS = 64;
    localparam logic [31:0] BASE = `LSU_SCRATCH_BASE;
    // one distinct byte per lane
    localparam logic [31:0] LANE_BYTES = 32'h35f0_7e81;

    logic                   clk;
    logic                   rst;
    lsu_pkg::ls_request_t   ls_inputs;
    logic                   new_request;
    logic                   wb_accepted;
    logic                   ready;
    logic                   wb_valid;
    logic [31:0]            wb_rd;
    logic                   exception_valid;
    lsu_pkg::ls_exception_t ls_exception;

    // byte model of the 4 KiB scratch region
    logic [7:0]             ref_mem [4096];
    logic [31:0]            exp_wb [$];
    lsu_pkg::ls_exception_t exp_exc [$];
    logic [31:0]            stim_state;
    logic [31:0]            accept_state;
    // 0 holds wb_accepted low, 1 takes every result, 2 takes at random
    int                     accept_mode;
    int                     errors;
    int                     checks;
    int                     tests_run;
    int                     test_fails;

    load_store_unit u_load_store_unit (
        .clk(clk),
        .rst(rst),
        .ls_inputs(ls_inputs),
        .new_request(new_request),
        .wb_accepted(wb_accepted),
        .ready(ready),
        .wb_valid(wb_valid),
        .wb_rd(wb_rd),
        .exception_valid(exception_valid),
        .ls_exception(ls_exception)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // initial word contents, a mix of every address bit
    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic lsu_pkg::ls_fn3_t pick_fn3(input logic [2:0] sel);
        lsu_pkg::ls_fn3_t f;
        case (sel)
            3'd0, 3'd5: f = lsu_pkg::LS_B;
            3'd1, 3'd6: f = lsu_pkg::LS_H;
            3'd3: f = lsu_pkg::LS_BU;
            3'd4: f = lsu_pkg::LS_HU;
            default: f = lsu_pkg::LS_W;
        endcase
        return f;
    endfunction

    // expected load value, built from the stored bytes
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input lsu_pkg::ls_fn3_t fn3);
        logic [11:0] a;
        logic [31:0] res;
        a = addr[11:0];
        case (fn3)
            lsu_pkg::LS_B: res = {{24{ref_mem[a][7]}}, ref_mem[a]};
            lsu_pkg::LS_BU: res = {24'd0, ref_mem[a]};
            lsu_pkg::LS_H: res = {{16{ref_mem[a + 12'd1][7]}}, ref_mem[a + 12'd1], ref_mem[a]};
            lsu_pkg::LS_HU: res = {16'd0, ref_mem[a + 12'd1], ref_mem[a]};
            default: res = {ref_mem[a + 12'd3], ref_mem[a + 12'd2],
                            ref_mem[a + 12'd1], ref_mem[a]};
        endcase
        return res;
    endfunction

    // little endian, low bytes of rs2 land at addr
    task automatic apply_store(input logic [31:0] addr, input lsu_pkg::ls_fn3_t fn3,
                               input logic [31:0] rs2);
        logic [11:0] a;
        a = addr[11:0];
        ref_mem[a] = rs2[7:0];
        if (fn3 != lsu_pkg::LS_B) begin
            ref_mem[a + 12'd1] = rs2[15:8];
        end
        if (fn3 == lsu_pkg::LS_W) begin
            ref_mem[a + 12'd2] = rs2[23:16];
            ref_mem[a + 12'd3] = rs2[31:24];
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    task automatic abort_run(input string why);
        $display("error at %0t ns: %s", $time, why);
        $display("tests failed");
        $finish;
    endtask

    // entered on a falling edge, leaves on the next one
    task automatic send_request(input logic [31:0] base, input logic [11:0] offset,
                                input logic [31:0] rs2, input lsu_pkg::ls_fn3_t fn3,
                                input logic is_load);
        logic [31:0] addr;
        logic mis;
        logic outside;
        int waited;
        lsu_pkg::ls_exception_t exc;
        waited = 0;
        while (!ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("ready stayed low, request could not be sent");
            end
        end
        ls_inputs.base = base;
        ls_inputs.offset = offset;
        ls_inputs.rs2 = rs2;
        ls_inputs.fn3 = fn3;
        ls_inputs.load = is_load;
        ls_inputs.store = !is_load;
        new_request = 1'b1;
        // effective address and fault rules
        addr = base + {{20{offset[11]}}, offset};
        case (fn3)
            lsu_pkg::LS_H, lsu_pkg::LS_HU: mis = addr[0];
            lsu_pkg::LS_W: mis = addr[1] | addr[0];
            default: mis = 1'b0;
        endcase
        // scratch region spans the whole RAM from its base
        outside = (addr < BASE) || (addr >= BASE + 32'(`LSU_RAM_WORDS * 4));
        if (mis || outside) begin
            exc.addr = addr;
            exc.misaligned = mis;
            exc.access_fault = outside;
            exp_exc.push_back(exc);
        end else if (is_load) begin
            exp_wb.push_back(expected_load(addr, fn3));
        end else begin
            apply_store(addr, fn3, rs2);
        end
        @(negedge clk);
        new_request = 1'b0;
    endtask

    task automatic drain(input string name);
        int waited;
        waited = 0;
        while (exp_wb.size() != 0 || exp_exc.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run({name, ": expected results never arrived"});
            end
        end
        // idle cycles so a stray writeback still shows
        repeat (4) @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (wb_valid) begin
            errors++;
            $display("error at %0t ns: unexpected result left in writeback buffer", $time);
        end
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            test_fails++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    // writeback side, driven on the falling edge
    always @(negedge clk) begin
        accept_state = xorshift32(accept_state);
        case (accept_mode)
            1: wb_accepted = wb_valid;
            2: wb_accepted = wb_valid && accept_state[3];
            default: wb_accepted = 1'b0;
        endcase
    end

    // compare against queued expectations at the rising edge
    always @(posedge clk) begin : compare
        logic [31:0] want_rd;
        lsu_pkg::ls_exception_t want_exc;
        if (!rst) begin
            if (wb_valid && wb_accepted) begin
                if (exp_wb.size() == 0) begin
                    errors++;
                    $display("error at %0t ns: writeback with no load outstanding", $time);
                end else begin
                    want_rd = exp_wb.pop_front();
                    check_value("wb_rd", 64'(wb_rd), 64'(want_rd));
                end
            end
            if (exception_valid) begin
                if (exp_exc.size() == 0) begin
                    errors++;
                    $display("error at %0t ns: exception for a legal access", $time);
                end else begin
                    want_exc = exp_exc.pop_front();
                    check_value("ls_exception", 64'(ls_exception), 64'(want_exc));
                end
            end
        end
    end

    initial begin
        int start;
        int waited;
        logic [31:0] r;
        logic [31:0] addr;
        logic [11:0] off;
        logic is_load;
        lsu_pkg::ls_fn3_t fn3;
        rst = 1'b1;
        new_request = 1'b0;
        wb_accepted = 1'b0;
        ls_inputs = '0;
        accept_mode = 0;
        stim_state = 32'd83;
        accept_state = 32'd83;
        errors = 0;
        checks = 0;
        tests_run = 0;
        test_fails = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        accept_mode = 1;

        // idle outputs straight out of reset
        start = errors;
        check_value("ready", 64'(ready), 64'd1);
        check_value("wb_valid", 64'(wb_valid), 64'd0);
        check_value("exception_valid", 64'(exception_valid), 64'd0);
        finish_test("reset state", start);

        // fill the window with words, then read them back
        start = errors;
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            send_request(BASE, 12'(i * 4), fill_pattern(BASE + 32'(i * 4)), lsu_pkg::LS_W, 1'b0);
        end
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            send_request(BASE, 12'(i * 4), 32'd0, lsu_pkg::LS_W, 1'b1);
        end
        drain("word store and load");
        finish_test("word store and load", start);

        // bytes into every lane of 0x200, halfwords into 0x204
        start = errors;
        for (int lane = 0; lane < 4; lane++) begin
            send_request(BASE, 12'(12'h200 + lane), {24'habcdef, LANE_BYTES[lane * 8 +: 8]},
                         lsu_pkg::LS_B, 1'b0);
        end
        send_request(BASE, 12'h204, 32'h1234_8001, lsu_pkg::LS_H, 1'b0);
        send_request(BASE, 12'h206, 32'h5678_7ffe, lsu_pkg::LS_H, 1'b0);
        for (int b = 0; b < 8; b++) begin
            send_request(BASE, 12'(12'h200 + b), 32'd0, lsu_pkg::LS_B, 1'b1);
            send_request(BASE, 12'(12'h200 + b), 32'd0, lsu_pkg::LS_BU, 1'b1);
            if (b % 2 == 0) begin
                send_request(BASE, 12'(12'h200 + b), 32'd0, lsu_pkg::LS_H, 1'b1);
                send_request(BASE, 12'(12'h200 + b), 32'd0, lsu_pkg::LS_HU, 1'b1);
            end
        end
        drain("sub-word lanes");
        finish_test("sub-word lanes", start);

        // random aligned mix, base and offset split at random
        start = errors;
        for (int n = 0; n < 200; n++) begin
            stim_state = xorshift32(stim_state);
            r = stim_state;
            fn3 = pick_fn3(r[2:0]);
            is_load = r[3];
            // stores only use the signed codes
            if (!is_load && fn3 == lsu_pkg::LS_BU) begin
                fn3 = lsu_pkg::LS_B;
            end
            if (!is_load && fn3 == lsu_pkg::LS_HU) begin
                fn3 = lsu_pkg::LS_H;
            end
            addr = BASE + {24'd0, r[9:4], r[11:10]};
            if (fn3 == lsu_pkg::LS_H || fn3 == lsu_pkg::LS_HU) begin
                addr[0] = 1'b0;
            end
            if (fn3 == lsu_pkg::LS_W) begin
                addr[1:0] = 2'b00;
            end
            off = r[23:12];
            stim_state = xorshift32(stim_state);
            send_request(addr - {{20{off[11]}}, off}, off, stim_state, fn3, is_load);
        end
        drain("random mix");
        finish_test("random mix", start);

        // faults, then check the touched words are unchanged
        start = errors;
        // top word of the region, where a wrapped index of BASE - 4 would land
        send_request(BASE + 32'h800, 12'h7fc, 32'h0bad_f00d, lsu_pkg::LS_W, 1'b0);
        send_request(BASE, 12'h001, 32'd0, lsu_pkg::LS_H, 1'b1);
        send_request(BASE, 12'h006, 32'hffff_ffff, lsu_pkg::LS_W, 1'b0);
        send_request(BASE, 12'h003, 32'h0000_eeee, lsu_pkg::LS_H, 1'b0);
        send_request(32'h9000_0000, 12'h000, 32'd0, lsu_pkg::LS_W, 1'b1);
        send_request(BASE, 12'hffc, 32'h1111_2222, lsu_pkg::LS_W, 1'b0);
        send_request(32'h4000_0000, 12'h001, 32'd0, lsu_pkg::LS_W, 1'b1);
        send_request(BASE, 12'h000, 32'd0, lsu_pkg::LS_W, 1'b1);
        send_request(BASE, 12'h004, 32'd0, lsu_pkg::LS_W, 1'b1);
        send_request(BASE + 32'h800, 12'h7fc, 32'd0, lsu_pkg::LS_W, 1'b1);
        drain("faults");
        finish_test("faults", start);

        // stall writeback until the request buffer fills
        start = errors;
        accept_mode = 0;
        for (int i = 0; i < 6; i++) begin
            send_request(BASE, 12'(i * 4), 32'd0, lsu_pkg::LS_W, 1'b1);
        end
        waited = 0;
        while (ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("ready never fell with writeback stalled");
            end
        end
        accept_mode = 2;
        for (int i = 0; i < 10; i++) begin
            stim_state = xorshift32(stim_state);
            r = stim_state;
            fn3 = pick_fn3(r[2:0]);
            addr = BASE + {24'd0, r[9:4], 2'b00};
            send_request(addr, 12'd0, 32'd0, fn3, 1'b1);
        end
        drain("back-pressure");
        finish_test("back-pressure", start);

        $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, test_fails, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
